// ==== sources.f ====
+incdir+src
src/isaPkg.sv
src/pipePkg.sv
src/instDecode.sv
src/hazardDetect.sv
src/destTracker.sv
src/issueStage.sv
dv/issueStageTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = issueStageTb
FILELIST  = sources.f
BUILD_DIR = obj_dir
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/issueStageTb.sv ====
// Issue stage testbench: LFSR stimulus, reference model, directed and random tests

`timescale 1ns/100ps

`include "pipeCfg_cfg.svh"

module issueStageTb;

    localparam int RESET_CYCLES = 4;
    localparam int DRAIN = 4;
    localparam int RAND_COUNT = 400;
    // Directed runs, up to six cycles per random instruction, resets, then margin
    localparam int TIMEOUT_CYCLES = 3 * RESET_CYCLES + 12 + 30 + 9 * 12 + 30
        + RAND_COUNT * 6 + 200;
    localparam logic [4:0] OP_ST = 5'b10000;
    localparam logic [4:0] OP_ADDI = 5'b01000;
    localparam logic [4:0] OP_JAL = 5'b00110;
    localparam logic [4:0] OP_JR = 5'b00101;

    logic         clk;
    logic         reset;
    isaPkg::instT fetchInst;
    isaPkg::instT nextInst;
    logic         pcNop;
    logic         halted;

    // Model state, index 0 is Decode
    logic           mWrt [4];
    isaPkg::regIdxT mReg [4];
    logic           mBrD;
    logic           mBrX;
    logic           mHalted;

    isaPkg::instT prog [$];
    logic [31:0]  lfsrState;
    int cycleCount = 0;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int stallCount;

    issueStage uut (
        .clk       (clk),
        .reset     (reset),
        .fetchInst (fetchInst),
        .nextInst  (nextInst),
        .pcNop     (pcNop),
        .halted    (halted)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [7:0] takeBits(input int count);
        logic [7:0] value;
        value = 8'h00;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h80200003 : lfsrState >> 1;
            value = {value[6:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic isaPkg::instT encode(input logic [4:0] op, input isaPkg::regIdxT rs,
                                            input isaPkg::regIdxT rt, input isaPkg::regIdxT rd);
        return {op, rs, rt, rd, 2'b00};
    endfunction

    // Decode table of the ISA, kept separately from the RTL
    task automatic decodeRef(input isaPkg::instT inst, output logic rsU, output logic rtU,
                             output logic wr, output isaPkg::regIdxT dst, output logic ctl);
        logic [4:0] op;
        op = inst[15:11];
        rsU = 1'b1;
        rtU = 1'b0;
        casez (op)
            5'b10000, 5'b10011, 5'b11011, 5'b11010, 5'b111??: rtU = 1'b1;
            5'b000??, 5'b00100, 5'b00110: rsU = 1'b0;
            default: ;
        endcase
        wr = 1'b1;
        casez (op)
            5'b11011, 5'b11010, 5'b111??, 5'b11001: dst = inst[4:2];
            5'b010??, 5'b101??, 5'b10001: dst = inst[7:5];
            5'b10011, 5'b11000, 5'b10010: dst = inst[10:8];
            5'b00110, 5'b00111: dst = `LINK_REG;
            default: begin
                wr = 1'b0;
                dst = 3'd0;
            end
        endcase
        ctl = !op[4] && op[2];
    endtask

    function automatic logic tracked(input isaPkg::regIdxT r);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (mWrt[i] && mReg[i] == r) hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic applyReset();
        reset = 1'b1;
        fetchInst = `NOP_INST;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < 4; i++) begin
            mWrt[i] = 1'b0;
            mReg[i] = 3'd0;
        end
        mBrD = 1'b0;
        mBrX = 1'b0;
        mHalted = 1'b0;
    endtask

    // One cycle: drive, check at mid-period, then advance the model at the edge
    task automatic runCycle(input string name);
        logic rsU;
        logic rtU;
        logic wr;
        logic ctl;
        logic expStall;
        isaPkg::regIdxT dst;
        isaPkg::instT expNext;
        fetchInst = (prog.size() > 0) ? prog[0] : `NOP_INST;
        #3;
        decodeRef(fetchInst, rsU, rtU, wr, dst, ctl);
        expStall = (rsU && tracked(fetchInst[10:8])) || (rtU && tracked(fetchInst[7:5]))
            || mBrD || mBrX || mHalted;
        expNext = expStall ? `NOP_INST : fetchInst;
        check({name, " nextInst"}, 32'(expNext), 32'(nextInst));
        check({name, " pcNop"}, 32'(expStall), 32'(pcNop));
        check({name, " halted"}, 32'(mHalted), 32'(halted));
        // Fetch holds its instruction while the stall is high
        if (prog.size() > 0) begin
            if (pcNop) stallCount++;
            else void'(prog.pop_front());
        end
        @(posedge clk);
        decodeRef(expNext, rsU, rtU, wr, dst, ctl);
        for (int i = 3; i > 0; i--) begin
            mWrt[i] = mWrt[i-1];
            mReg[i] = mReg[i-1];
        end
        mWrt[0] = wr;
        mReg[0] = dst;
        mBrX = mBrD;
        mBrD = !expStall && ctl;
        if (!expStall && expNext[15:11] == `HALT_OPCODE) mHalted = 1'b1;
        #1;
    endtask

    task automatic runProgram(input string name, input int expStalls);
        stallCount = 0;
        while (prog.size() > 0) runCycle(name);
        repeat (DRAIN) runCycle(name);
        if (expStalls >= 0) check({name, " stall cycles"}, 32'(expStalls), 32'(stallCount));
    endtask

    // Sources in r0 to r3, destinations in r4 to r6
    task automatic loadIndependent(input int count);
        for (int i = 0; i < count; i++) begin
            if (i % 2 == 0) prog.push_back(encode(OP_ADDI, 3'(i % 4), 3'(4 + i % 3), 3'd0));
            else prog.push_back(encode(OP_ST, 3'(i % 4), 3'((i + 1) % 4), 3'd0));
        end
    endtask

    task automatic loadRandom(input int count);
        logic [7:0] grp;
        logic [7:0] low;
        logic [7:0] rs;
        logic [7:0] rt;
        logic [7:0] rd;
        logic [4:0] op;
        for (int i = 0; i < count; i++) begin
            grp = takeBits(3);
            low = takeBits(2);
            case (grp[2:0])
                3'd0, 3'd1: op = {3'b111, low[1:0]};
                3'd2: op = {3'b110, low[1:0]};
                3'd3: op = {3'b010, low[1:0]};
                3'd4: op = {3'b101, low[1:0]};
                3'd5: op = {3'b100, low[1:0]};
                3'd6: op = {3'b001, low[1:0]};
                default: op = {3'b011, low[1:0]};
            endcase
            // Narrow register range keeps hazards frequent
            rs = takeBits(2);
            rt = takeBits(2);
            rd = takeBits(2);
            prog.push_back(encode(op, {1'b0, rs[1:0]}, {1'b0, rt[1:0]}, {1'b0, rd[1:0]}));
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        tests++;
        $display("Test %0d %s finished with %0d errors", tests, name, errors - errorsBefore);
    endtask

    initial begin
        int startErr;
        logic [4:0] op;
        clk = 1'b0;
        reset = 1'b1;
        fetchInst = `NOP_INST;
        lfsrState = 32'hd9eaf681;
        applyReset();

        startErr = errors;
        loadIndependent(8);
        runProgram("independent", 0);
        reportTest("independent stream", startErr);

        // Writer then reader, in both source positions and through the link register
        startErr = errors;
        prog = '{encode(OP_ADDI, 3'd0, 3'd3, 3'd0), encode(OP_ADDI, 3'd3, 3'd5, 3'd0)};
        runProgram("raw rs", 4);
        prog = '{encode(OP_ADDI, 3'd0, 3'd3, 3'd0), encode(OP_ST, 3'd1, 3'd3, 3'd0)};
        runProgram("raw rt", 4);
        prog = '{encode(OP_JAL, 3'd0, 3'd0, 3'd0), encode(OP_ADDI, `LINK_REG, 3'd4, 3'd0)};
        runProgram("raw link", 4);
        reportTest("read after write", startErr);

        startErr = errors;
        for (int k = 0; k < 8; k++) begin
            op = {1'b0, k[2], 1'b1, k[1:0]};
            prog = '{encode(op, 3'd2, 3'd0, 3'd0), encode(OP_ST, 3'd0, 3'd1, 3'd0)};
            runProgram($sformatf("control %b", op), 2);
        end
        // Four cycles for the hazard on r2, then two for the jump itself
        prog = '{encode(OP_ADDI, 3'd0, 3'd2, 3'd0), encode(OP_JR, 3'd2, 3'd0, 3'd0),
                 encode(OP_ST, 3'd0, 3'd1, 3'd0)};
        runProgram("control hazard", 6);
        reportTest("control flow", startErr);

        startErr = errors;
        loadRandom(RAND_COUNT);
        runProgram("random", -1);
        reportTest("random stream", startErr);

        startErr = errors;
        prog = '{{`HALT_OPCODE, 11'd0}, encode(OP_ST, 3'd0, 3'd1, 3'd0)};
        repeat (10) runCycle("halt");
        check("halt halted", 1, 32'(halted));
        check("halt fetch held", 1, 32'(prog.size()));
        prog.delete();
        applyReset();
        loadIndependent(4);
        runProgram("after halt", 0);
        reportTest("halt", startErr);

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== src/issueStage.sv ====
// Issue stage top: hazard detector beside the destination tracker

`timescale 1ns/100ps

module issueStage (
    input  logic         clk,
    input  logic         reset,
    input  isaPkg::instT fetchInst,
    output isaPkg::instT nextInst,
    output logic         pcNop,
    output logic         halted
);

    pipePkg::stageVecT regWrt;
    isaPkg::regIdxT    wrtRegD;
    isaPkg::regIdxT    wrtRegX;
    isaPkg::regIdxT    wrtRegM;
    isaPkg::regIdxT    wrtRegW;
    logic              branchInstF;
    logic              branchInstD;
    logic              branchInstX;

    hazardDetect detector (
        .clk         (clk),
        .reset       (reset),
        .fetchInst   (fetchInst),
        .regWrt      (regWrt),
        .wrtRegD     (wrtRegD),
        .wrtRegX     (wrtRegX),
        .wrtRegM     (wrtRegM),
        .wrtRegW     (wrtRegW),
        .branchInstD (branchInstD),
        .branchInstX (branchInstX),
        .nextInst    (nextInst),
        .pcNop       (pcNop),
        .branchInstF (branchInstF),
        .halted      (halted)
    );

    // Stands in for the D, X, M, W pipeline registers
    destTracker tracker (
        .clk         (clk),
        .reset       (reset),
        .nextInst    (nextInst),
        .branchInstF (branchInstF),
        .regWrt      (regWrt),
        .wrtRegD     (wrtRegD),
        .wrtRegX     (wrtRegX),
        .wrtRegM     (wrtRegM),
        .wrtRegW     (wrtRegW),
        .branchInstD (branchInstD),
        .branchInstX (branchInstX)
    );

endmodule

// ==== src/destTracker.sv ====
// Destination tracker: write records through D, X, M, W and branch flags through D, X

`timescale 1ns/100ps

`include "pipeCfg_cfg.svh"

module destTracker (
    input  logic              clk,
    input  logic              reset,
    input  isaPkg::instT      nextInst,
    input  logic              branchInstF,
    output pipePkg::stageVecT regWrt,
    output isaPkg::regIdxT    wrtRegD,
    output isaPkg::regIdxT    wrtRegX,
    output isaPkg::regIdxT    wrtRegM,
    output isaPkg::regIdxT    wrtRegW,
    output logic              branchInstD,
    output logic              branchInstX
);

    logic           newWrt;
    isaPkg::regIdxT newReg;

    instDecode issueDecode (
        .inst      (nextInst),
        .rsUsed    (),
        .rtUsed    (),
        .rsReg     (),
        .rtReg     (),
        .regWrt    (newWrt),
        .wrtReg    (newReg),
        .isControl ()
    );

    // Enables and branch flags
    always_ff @(posedge clk) begin
        if (reset) begin
            regWrt      <= '0;
            branchInstD <= 1'b0;
            branchInstX <= 1'b0;
        end else begin
            regWrt      <= {regWrt[pipePkg::STG_M:pipePkg::STG_D], newWrt};
            branchInstD <= branchInstF;
            branchInstX <= branchInstD;
        end
    end

    // Register indices, only meaningful where the enable is set
    always_ff @(posedge clk) begin
        wrtRegD <= newReg;
        wrtRegX <= wrtRegD;
        wrtRegM <= wrtRegX;
        wrtRegW <= wrtRegM;
    end

    nopWritesNothing: assert property (@(posedge clk) disable iff (reset)
        nextInst == `NOP_INST |=> !regWrt[pipePkg::STG_D]);

endmodule

// ==== src/hazardDetect.sv ====
// Hazard detector: source compare against tracked writers, stall, NOP insertion and halt FSM

`timescale 1ns/100ps

`include "pipeCfg_cfg.svh"

module hazardDetect (
    input  logic             clk,
    input  logic             reset,
    input  isaPkg::instT     fetchInst,
    input  pipePkg::stageVecT regWrt,
    input  isaPkg::regIdxT   wrtRegD,
    input  isaPkg::regIdxT   wrtRegX,
    input  isaPkg::regIdxT   wrtRegM,
    input  isaPkg::regIdxT   wrtRegW,
    input  logic             branchInstD,
    input  logic             branchInstX,
    output isaPkg::instT     nextInst,
    output logic             pcNop,
    output logic             branchInstF,
    output logic             halted
);

    logic              rsUsed;
    logic              rtUsed;
    isaPkg::regIdxT    rsReg;
    isaPkg::regIdxT    rtReg;
    logic              isControl;
    pipePkg::stageVecT rsMatch;
    pipePkg::stageVecT rtMatch;
    logic              rsHazard;
    logic              rtHazard;
    logic              issue;
    logic              haltIssued;
    pipePkg::haltStateT state;

    instDecode fetchDecode (
        .inst      (fetchInst),
        .rsUsed    (rsUsed),
        .rtUsed    (rtUsed),
        .rsReg     (rsReg),
        .rtReg     (rtReg),
        .regWrt    (),
        .wrtReg    (),
        .isControl (isControl)
    );

    // Per-stage register compare in the bit order of regWrt
    assign rsMatch = {rsReg == wrtRegW, rsReg == wrtRegM, rsReg == wrtRegX, rsReg == wrtRegD};
    assign rtMatch = {rtReg == wrtRegW, rtReg == wrtRegM, rtReg == wrtRegX, rtReg == wrtRegD};

    assign rsHazard = rsUsed && |(rsMatch & regWrt);
    assign rtHazard = rtUsed && |(rtMatch & regWrt);

    // Control flow in D or X still has to resolve
    assign pcNop = rsHazard || rtHazard || branchInstD || branchInstX || halted;

    assign issue       = !(pcNop || reset);
    assign nextInst    = issue ? fetchInst : `NOP_INST;
    assign branchInstF = issue && isControl;

    assign haltIssued = issue &&
        (fetchInst[isaPkg::OPCODE_LSB +: isaPkg::OPCODE_WIDTH] == `HALT_OPCODE);

    // Halt FSM stays halted until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= pipePkg::stIssuing;
        end else if (haltIssued) begin
            state <= pipePkg::stHalted;
        end
    end

    assign halted = (state == pipePkg::stHalted);

    // Fetch keeps a stalled instruction in place
    fetchHeldOnStall: assert property (@(posedge clk) disable iff (reset)
        pcNop |=> fetchInst == $past(fetchInst));

    // Two NOPs follow every issued control-flow instruction
    oneBranchInFlight: assert property (@(posedge clk) disable iff (reset)
        branchInstD |-> !branchInstX);

endmodule

// ==== src/instDecode.sv ====
// Instruction decoder: source usage, source registers, destination and control-flow flag

`timescale 1ns/100ps

`include "pipeCfg_cfg.svh"

module instDecode (
    input  isaPkg::instT   inst,
    output logic           rsUsed,
    output logic           rtUsed,
    output isaPkg::regIdxT rsReg,
    output isaPkg::regIdxT rtReg,
    output logic           regWrt,
    output isaPkg::regIdxT wrtReg,
    output logic           isControl
);

    isaPkg::opcodeT opcode;
    isaPkg::regIdxT rdReg;

    // Raw fields
    assign opcode = inst[isaPkg::OPCODE_LSB +: isaPkg::OPCODE_WIDTH];
    assign rsReg  = inst[isaPkg::RS_LSB +: isaPkg::REG_IDX_WIDTH];
    assign rtReg  = inst[isaPkg::RT_LSB +: isaPkg::REG_IDX_WIDTH];
    assign rdReg  = inst[isaPkg::RD_LSB +: isaPkg::REG_IDX_WIDTH];

    // Which source fields are actually read
    always_comb begin
        casez (opcode)
            // ST, STU read the data register in bits 7 to 5
            5'b10000, 5'b10011: begin
                rsUsed = 1'b1;
                rtUsed = 1'b1;
            end
            // Register-register ALU and set ops
            5'b11011, 5'b11010, 5'b111??: begin
                rsUsed = 1'b1;
                rtUsed = 1'b1;
            end
            // NOP, HALT, siic, RTI
            5'b000??: begin
                rsUsed = 1'b0;
                rtUsed = 1'b0;
            end
            // J and JAL use only a displacement
            5'b00100, 5'b00110: begin
                rsUsed = 1'b0;
                rtUsed = 1'b0;
            end
            default: begin
                rsUsed = 1'b1;
                rtUsed = 1'b0;
            end
        endcase
    end

    // Destination register and its write enable
    always_comb begin
        casez (opcode)
            5'b11011, 5'b11010, 5'b111??, 5'b11001: begin
                regWrt = 1'b1;
                wrtReg = rdReg;
            end
            // Immediate ALU ops, shifts and LD write bits 7 to 5
            5'b010??, 5'b101??, 5'b10001: begin
                regWrt = 1'b1;
                wrtReg = rtReg;
            end
            // STU updates its base, LBI and SLBI load into rs
            5'b10011, 5'b11000, 5'b10010: begin
                regWrt = 1'b1;
                wrtReg = rsReg;
            end
            5'b00110, 5'b00111: begin
                regWrt = 1'b1;
                wrtReg = `LINK_REG;
            end
            default: begin
                regWrt = 1'b0;
                wrtReg = rdReg;
            end
        endcase
    end

    // Jumps 001xx and branches 011xx
    assign isControl = (opcode[4:3] == 2'b00 || opcode[4:3] == 2'b01) && opcode[2];

endmodule

// ==== src/pipePkg.sv ====
// Pipeline-control types: halt state and per-stage valid vector

package pipePkg;

    // Stages tracked behind issue
    localparam int NUM_STAGES = 4;

    // Bit positions inside a stage vector
    localparam int STG_D = 0;
    localparam int STG_X = 1;
    localparam int STG_M = 2;
    localparam int STG_W = 3;

    // One bit per stage, Decode in bit 0
    typedef logic [NUM_STAGES-1:0] stageVecT;

    // Issue runs until a HALT goes out
    typedef enum logic {
        stIssuing = 1'b0,
        stHalted  = 1'b1
    } haltStateT;

endpackage

// ==== src/isaPkg.sv ====
// Instruction-set types: instruction word, opcode field, register index, field positions

`include "pipeCfg_cfg.svh"

package isaPkg;

    // Field widths
    localparam int OPCODE_WIDTH = 5;
    localparam int REG_IDX_WIDTH = `REG_IDX_WIDTH;

    // Least significant bit of each instruction field
    localparam int OPCODE_LSB = `INST_WIDTH - OPCODE_WIDTH;
    localparam int RS_LSB = 8;
    localparam int RT_LSB = 5;
    localparam int RD_LSB = 2;

    // Full instruction word
    typedef logic [`INST_WIDTH-1:0] instT;

    // Opcode field, bits 15 to 11
    typedef logic [OPCODE_WIDTH-1:0] opcodeT;

    // Index into the eight-entry register file
    typedef logic [REG_IDX_WIDTH-1:0] regIdxT;

endpackage

// ==== src/pipeCfg_cfg.svh ====
// Widths and fixed encodings for the issue front end

`ifndef PIPE_CFG_CFG_SVH
`define PIPE_CFG_CFG_SVH

// Datapath widths
`define INST_WIDTH 16
`define REG_IDX_WIDTH 3

// NOP is opcode 00001 with all other bits clear
`define NOP_INST 16'b00001_000_0000_0000

// Opcode that stops issue until reset
`define HALT_OPCODE 5'b00000

// JAL and JALR write their return address here
`define LINK_REG 3'd7

`endif
